// File: line_buffer.sv
// Refill line RAM with a byte-masked port for the bus, a word port for the engine and clean flags.
`default_nettype none
`timescale 1ns/100ps

module line_buffer import sdram_port_pkg::*; #(
	parameter int line_log2 = DEF_LINE_LOG2
) (
	input  wire logic                 wb_clk,
	input  wire logic                 sdram_rst,
	input  wire logic [line_log2-1:0] a_adr_i,
	input  wire logic [3:0]           a_we_i,
	input  wire logic [31:0]          a_wdata_i,
	output logic [31:0]               a_rdata_o,
	input  wire logic [line_log2-1:0] b_adr_i,
	input  wire logic                 b_we_i,
	input  wire logic [31:0]          b_wdata_i,
	input  wire logic                 clear_i,
	output logic [(1<<line_log2)-1:0] clean_o
);

	localparam int WORDS = 1 << line_log2;

	logic [31:0] mem [WORDS];

	// ########################################################################
	// storage
	// ########################################################################

	// port b stores whole words from memory, port a merges the selected bytes.
	always_ff @(posedge wb_clk) begin
		if (b_we_i)
			mem[b_adr_i] <= b_wdata_i;
		for (int i = 0; i < 4; i++) begin
			if (a_we_i[i])
				mem[a_adr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
		end
		a_rdata_o <= mem[a_adr_i]; // registered read of the presented address.
	end

	// ########################################################################
	// clean flags
	// ########################################################################

	always_ff @(posedge wb_clk) begin
		if (sdram_rst)
			clean_o <= '0;
		else if (clear_i)
			clean_o <= '0; // a new line is on its way.
		else if (b_we_i)
			clean_o[b_adr_i] <= 1'b1;
	end

endmodule

`default_nettype wire

// File: port_fifo.sv
// Synchronous queue for posted writes, with the payload given as a type parameter.
`default_nettype none
`timescale 1ns/100ps

module port_fifo import sdram_port_pkg::*; #(
	parameter int  fifo_log2 = DEF_FIFO_LOG2,
	parameter type payload_t = logic [31:0]
) (
	input  wire logic     wb_clk,
	input  wire logic     sdram_rst,
	input  wire logic     push_i,
	input  wire payload_t data_i,
	input  wire logic     pop_i,
	output payload_t      head_o,
	output logic          full_o,
	output logic          empty_o
);

	localparam int DEPTH = 1 << fifo_log2;

	payload_t             mem [DEPTH];
	logic [fifo_log2-1:0] wr_ptr;
	logic [fifo_log2-1:0] rd_ptr;
	logic [fifo_log2:0]   count;  // one bit wider so a full queue is visible.
	logic                 do_push;
	logic                 do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge wb_clk) begin
		if (sdram_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// a push and a pop together leave the count unchanged.
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge wb_clk) begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

	assign head_o  = mem[rd_ptr]; // head is visible without a read cycle.
	assign full_o  = (count == DEPTH[fifo_log2:0]);
	assign empty_o = (count == '0);

endmodule

`default_nettype wire

// File: sdram_mem_model.sv
// Testbench SDRAM model answering four-phase word requests after a programmable delay.
`default_nettype none
`timescale 1ns/100ps

module sdram_mem_model import sdram_port_pkg::*; #(
	parameter int words_log2 = 10
) (
	input  wire logic       wb_clk,
	input  wire logic       sdram_rst,
	input  wire logic       req_i,
	input  wire mem_req_t   cmd_i,
	input  wire logic [7:0] delay_i,
	output logic            ack_o,
	output logic [31:0]     rdata_o
);

	logic [31:0] mem [1 << words_log2];
	logic [7:0]  wait_cnt;
	logic [words_log2-1:0] idx;

	assign idx = cmd_i.adr[words_log2+1:2];

	// every word starts as its word address mixed with a fixed marker.
	initial begin
		for (int i = 0; i < (1 << words_log2); i++)
			mem[i] = i ^ 32'h5a5a0000;
	end

	always @(posedge wb_clk) begin
		if (sdram_rst) begin
			ack_o    <= 1'b0;
			wait_cnt <= '0;
		end else if (req_i && !ack_o) begin
			if (wait_cnt < delay_i) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
				ack_o    <= 1'b1;
				if (cmd_i.we) begin
					for (int b = 0; b < 4; b++)
						if (cmd_i.sel[b])
							mem[idx][8*b +: 8] <= cmd_i.dat[8*b +: 8];
				end else begin
					rdata_o <= mem[idx]; // held while ack stays high.
				end
			end
		end else if (!req_i && ack_o) begin
			ack_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: sdram_port_pkg.sv
// Shared types, Wishbone cycle and burst codes, and default sizes for the SDRAM port.
`default_nettype none

package sdram_port_pkg;

	// ########################################################################
	// wishbone registered feedback codes
	// ########################################################################

	// cycle type identifier, carried on cti.
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_CONST   = 3'b001, // handled like a classic cycle by this port.
		CTI_INC     = 3'b010,
		CTI_END     = 3'b111
	} cti_e;

	// burst type extension, carried on bte.
	typedef enum logic [1:0] {
		BTE_LINEAR = 2'b00,
		BTE_WRAP4  = 2'b01,
		BTE_WRAP8  = 2'b10,
		BTE_WRAP16 = 2'b11
	} bte_e;

	// ########################################################################
	// bundles
	// ########################################################################

	// one wishbone request as the master presents it, 74 bits.
	typedef struct packed {
		logic [31:0] adr; // byte address.
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic [2:0]  cti;
		logic [1:0]  bte;
	} wb_req_t;

	// one posted write waiting in the queue, 66 bits.
	typedef struct packed {
		logic [29:0] adr; // word address.
		logic [31:0] dat;
		logic [3:0]  sel;
	} wr_entry_t;

	// one word transaction toward memory.
	typedef struct packed {
		logic [31:0] adr; // byte address, low two bits are always zero.
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
	} mem_req_t;

	// default sizes, both as log2.
	localparam int DEF_LINE_LOG2 = 3; // words per refill line.
	localparam int DEF_FIFO_LOG2 = 3; // entries in the write queue.

endpackage

`default_nettype wire

// File: sdram_port_top.sv
// Top of the Wishbone SDRAM port, joining front end, write queue, line buffer and engine.
`default_nettype none
`timescale 1ns/100ps

module sdram_port_top import sdram_port_pkg::*; #(
	parameter int line_log2 = DEF_LINE_LOG2,
	parameter int fifo_log2 = DEF_FIFO_LOG2
) (
	input  wire logic        wb_clk,
	input  wire logic        sdram_rst,
	input  wire logic        wb_cyc_i,
	input  wire logic        wb_stb_i,
	input  wire wb_req_t     wb_req_i,
	output logic [31:0]      wb_dat_o,
	output logic             wb_ack_o,
	output logic             mem_req_o,
	output mem_req_t         mem_cmd_o,
	input  wire logic        mem_ack_i,
	input  wire logic [31:0] mem_rdata_i
);

	// ########################################################################
	// internal nets
	// ########################################################################

	logic                      wq_push;
	wr_entry_t                 wq_data;
	logic                      wq_full;
	logic                      wq_empty;
	wr_entry_t                 wq_head;
	logic                      wq_pop;
	logic                      refill_req;
	logic [31:0]               refill_adr;
	logic                      refill_done;
	logic [line_log2-1:0]      a_adr;
	logic [3:0]                a_we;
	logic [31:0]               a_wdata;
	logic [31:0]               a_rdata;
	logic [line_log2-1:0]      b_adr;
	logic                      b_we;
	logic [31:0]               b_wdata;
	logic                      buf_clear;
	logic [(1<<line_log2)-1:0] clean;

	wb_slave_port #(
		.line_log2 (line_log2)
	) u_front (
		.wb_clk        (wb_clk),
		.sdram_rst     (sdram_rst),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_req_i      (wb_req_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.wq_full_i     (wq_full),
		.wq_push_o     (wq_push),
		.wq_data_o     (wq_data),
		.refill_req_o  (refill_req),
		.refill_adr_o  (refill_adr),
		.refill_done_i (refill_done),
		.clean_i       (clean),
		.buf_adr_o     (a_adr),
		.buf_we_o      (a_we),
		.buf_wdata_o   (a_wdata),
		.buf_rdata_i   (a_rdata)
	);

	port_fifo #(
		.fifo_log2 (fifo_log2),
		.payload_t (wr_entry_t)
	) u_wq (
		.wb_clk    (wb_clk),
		.sdram_rst (sdram_rst),
		.push_i    (wq_push),
		.data_i    (wq_data),
		.pop_i     (wq_pop),
		.head_o    (wq_head),
		.full_o    (wq_full),
		.empty_o   (wq_empty)
	);

	line_buffer #(
		.line_log2 (line_log2)
	) u_lbuf (
		.wb_clk    (wb_clk),
		.sdram_rst (sdram_rst),
		.a_adr_i   (a_adr),
		.a_we_i    (a_we),
		.a_wdata_i (a_wdata),
		.a_rdata_o (a_rdata),
		.b_adr_i   (b_adr),
		.b_we_i    (b_we),
		.b_wdata_i (b_wdata),
		.clear_i   (buf_clear),
		.clean_o   (clean)
	);

	sdram_side_engine #(
		.line_log2 (line_log2)
	) u_engine (
		.wb_clk        (wb_clk),
		.sdram_rst     (sdram_rst),
		.wq_empty_i    (wq_empty),
		.wq_head_i     (wq_head),
		.wq_pop_o      (wq_pop),
		.refill_req_i  (refill_req),
		.refill_adr_i  (refill_adr),
		.refill_done_o (refill_done),
		.buf_clear_o   (buf_clear),
		.buf_adr_o     (b_adr),
		.buf_we_o      (b_we),
		.buf_wdata_o   (b_wdata),
		.mem_req_o     (mem_req_o),
		.mem_cmd_o     (mem_cmd_o),
		.mem_ack_i     (mem_ack_i),
		.mem_rdata_i   (mem_rdata_i)
	);

endmodule

`default_nettype wire

// File: sdram_side_engine.sv
// Memory-side engine that drains posted writes and refills the line buffer word by word.
`default_nettype none
`timescale 1ns/100ps

module sdram_side_engine import sdram_port_pkg::*; #(
	parameter int line_log2 = DEF_LINE_LOG2
) (
	input  wire logic        wb_clk,
	input  wire logic        sdram_rst,
	input  wire logic        wq_empty_i,
	input  wire wr_entry_t   wq_head_i,
	output logic             wq_pop_o,
	input  wire logic        refill_req_i,
	input  wire logic [31:0] refill_adr_i,
	output logic             refill_done_o,
	output logic             buf_clear_o,
	output logic [line_log2-1:0] buf_adr_o,
	output logic             buf_we_o,
	output logic [31:0]      buf_wdata_o,
	output logic             mem_req_o,
	output mem_req_t         mem_cmd_o,
	input  wire logic        mem_ack_i,
	input  wire logic [31:0] mem_rdata_i
);

	localparam int TAG_LSB = line_log2 + 2;

	typedef enum logic [2:0] {
		E_IDLE,
		E_WR,      // the write request is up until ack arrives.
		E_WR_REL,  // the request is down until ack falls.
		E_RD,
		E_RD_REL,
		E_DONE
	} state_e;

	state_e               state;
	logic [line_log2-1:0] cnt;  // word of the line being fetched.

	// idle is only reached with ack low, so the head can go out at once.
	assign wq_pop_o = (state == E_IDLE) && !wq_empty_i;

	always_ff @(posedge wb_clk) begin
		if (sdram_rst) begin
			state         <= E_IDLE;
			mem_req_o     <= 1'b0;
			refill_done_o <= 1'b0;
			buf_clear_o   <= 1'b0;
			buf_we_o      <= 1'b0;
			cnt           <= '0;
		end else begin
			buf_clear_o <= 1'b0;
			buf_we_o    <= 1'b0;
			case (state)
				E_IDLE: begin
					// posted writes always go first, so a refill never reads stale data.
					if (!wq_empty_i) begin
						mem_cmd_o.adr <= {wq_head_i.adr, 2'b00};
						mem_cmd_o.dat <= wq_head_i.dat;
						mem_cmd_o.sel <= wq_head_i.sel;
						mem_cmd_o.we  <= 1'b1;
						mem_req_o     <= 1'b1;
						state         <= E_WR;
					end else if (refill_req_i) begin
						buf_clear_o   <= 1'b1;
						cnt           <= '0;
						mem_cmd_o.adr <= {refill_adr_i[31:TAG_LSB], {line_log2{1'b0}}, 2'b00};
						mem_cmd_o.dat <= '0;
						mem_cmd_o.sel <= 4'hf;
						mem_cmd_o.we  <= 1'b0;
						mem_req_o     <= 1'b1;
						state         <= E_RD;
					end
				end
				E_WR: begin
					if (mem_ack_i) begin
						mem_req_o <= 1'b0;
						state     <= E_WR_REL;
					end
				end
				E_WR_REL: begin
					if (!mem_ack_i)
						state <= E_IDLE;
				end
				E_RD: begin
					if (mem_ack_i) begin
						// read data is valid while ack is high.
						mem_req_o   <= 1'b0;
						buf_we_o    <= 1'b1;
						buf_adr_o   <= cnt;
						buf_wdata_o <= mem_rdata_i;
						state       <= E_RD_REL;
					end
				end
				E_RD_REL: begin
					if (!mem_ack_i) begin
						if (&cnt) begin
							refill_done_o <= 1'b1; // last word is already stored.
							state         <= E_DONE;
						end else begin
							cnt           <= cnt + 1'b1;
							mem_cmd_o.adr <= {refill_adr_i[31:TAG_LSB], cnt + 1'b1, 2'b00};
							mem_req_o     <= 1'b1;
							state         <= E_RD;
						end
					end
				end
				E_DONE: begin
					if (!refill_req_i) begin
						refill_done_o <= 1'b0;
						state         <= E_IDLE;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sources.f
sdram_port_pkg.sv
port_fifo.sv
line_buffer.sv
wb_slave_port.sv
sdram_side_engine.sv
sdram_port_top.sv
sdram_mem_model.sv
tb_sdram_port.sv

// File: tb_sdram_port.sv
// Directed testbench for the Wishbone SDRAM port with a four-phase memory model.
`default_nettype none
`timescale 1ns/100ps

module tb_sdram_port import sdram_port_pkg::*; ();

	localparam int OP_LIMIT = 600; // cycles one beat may wait for its ack.
	localparam int WATCHDOG_CYCLES = 400 + 400 + 1200 + 1500 + 3000;

	logic        wb_clk;
	logic        sdram_rst;
	logic        wb_cyc;
	logic        wb_stb;
	wb_req_t     wb_req;
	logic [31:0] wb_dat;
	logic        wb_ack;
	logic        mem_req;
	mem_req_t    mem_cmd;
	logic        mem_ack;
	logic [31:0] mem_rdata;
	logic [7:0]  ack_delay;
	logic [31:0] shadow [1024];
	mem_req_t    seen_q [$];
	mem_req_t    exp_q [$];
	logic        req_seen;
	int          n_checks;
	int          n_errors;
	int          seed;

	sdram_port_top #(.line_log2(3), .fifo_log2(DEF_FIFO_LOG2)) UUT (
		.wb_clk(wb_clk), .sdram_rst(sdram_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
		.wb_req_i(wb_req), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack), .mem_req_o(mem_req),
		.mem_cmd_o(mem_cmd), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
	);

	sdram_mem_model u_mem (
		.wb_clk(wb_clk), .sdram_rst(sdram_rst), .req_i(mem_req), .cmd_i(mem_cmd),
		.delay_i(ack_delay), .ack_o(mem_ack), .rdata_o(mem_rdata)
	);

	initial begin
		wb_clk = 1'b0;
		forever #20 wb_clk = ~wb_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 40);
		$display("watchdog expired after %0d cycles, the DUT stopped responding",
			WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	// capture every memory write command on the rising request.
	always @(negedge wb_clk) begin
		if (mem_req && !req_seen && mem_cmd.we)
			seen_q.push_back(mem_cmd);
		req_seen = mem_req;
	end

	// ########################################################################
	// compare tasks and helpers
	// ########################################################################

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
			input string msg);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_cmd(input mem_req_t got, input mem_req_t exp, input string msg);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display({"MISMATCH at %0d ns: %s got adr %h dat %h sel %h we %b,",
				" expected %h %h %h %b"}, $time, msg, got.adr, got.dat, got.sel,
				got.we, exp.adr, exp.dat, exp.sel, exp.we);
		end
	endtask

	// the low bits advance by a word inside the wrap block, the rest stays.
	function automatic logic [31:0] beat_adr(input logic [31:0] start, input int k,
			input logic [1:0] bte);
		logic [31:0] span;
		case (bte)
			2'd0: return start + 4 * k;
			2'd1: span = 16;
			2'd2: span = 32;
			default: span = 64;
		endcase
		return (start & ~(span - 1)) | ((start + 4 * k) & (span - 1));
	endfunction

	// the master keeps the last acked address up, or the one still awaited.
	task automatic read_burst(input logic [31:0] start, input int beats, input logic [1:0] bte,
			input logic [2:0] cti);
		logic [31:0] adrs [16];
		int want;
		int waited;
		for (int k = 0; k < beats; k++)
			adrs[k] = beat_adr(start, k, bte);
		want = 0;
		waited = 0;
		@(negedge wb_clk);
		wb_req = '{adr: adrs[0], dat: 32'h0, sel: 4'hf, we: 1'b0, cti: cti, bte: bte};
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		while (want < beats) begin
			@(negedge wb_clk);
			if (wb_ack) begin
				check_word(wb_dat, shadow[adrs[want][11:2]],
					$sformatf("read %h", adrs[want]));
				want++;
				waited = 0;
				wb_req.adr = adrs[want - 1];
			end else begin
				waited++;
				wb_req.adr = adrs[want];
				if (waited > OP_LIMIT) begin
					n_errors++;
					$display("read of %h was never acknowledged", adrs[want]);
					break;
				end
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		int waited;
		mem_req_t cmd;
		waited = 0;
		@(negedge wb_clk);
		wb_req = '{adr: adr, dat: dat, sel: sel, we: 1'b1, cti: CTI_CLASSIC, bte: BTE_LINEAR};
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(negedge wb_clk);
			waited++;
		end while (!wb_ack && waited <= OP_LIMIT);
		if (!wb_ack) begin
			n_errors++;
			$display("write to %h was never acknowledged", adr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				shadow[adr[11:2]][8*b +: 8] = dat[8*b +: 8];
		cmd = '{adr: {adr[31:2], 2'b00}, dat: dat, sel: sel, we: 1'b1};
		exp_q.push_back(cmd);
	endtask

	task automatic wait_mem_idle(input int n_cmds);
		int waited;
		waited = 0;
		do begin
			@(negedge wb_clk);
			waited++;
		end while ((seen_q.size() < n_cmds || mem_req || mem_ack) && waited <= 4 * OP_LIMIT);
		if (waited > 4 * OP_LIMIT) begin
			n_errors++;
			$display("memory side did not go idle after %0d write commands", n_cmds);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("[%0d ns] %s finished with %0d errors", $time, name, n_errors - errs_before);
	endtask

	// ########################################################################
	// tests
	// ########################################################################

	task automatic reset_first_read();
		int e0;
		e0 = n_errors;
		check_word({31'b0, wb_ack}, 32'h0, "wb_ack_o after reset");
		check_word({31'b0, mem_req}, 32'h0, "mem_req_o after reset");
		read_burst(32'h100, 1, BTE_LINEAR, CTI_CLASSIC);
		report_test("reset", e0);
	endtask

	task automatic linear_hit_burst();
		int e0;
		e0 = n_errors;
		read_burst(32'h204, 1, BTE_LINEAR, CTI_CLASSIC); // brings in line 0x200.
		read_burst(32'h200, 8, BTE_LINEAR, CTI_INC);
		report_test("read hit burst", e0);
	endtask

	task automatic wrap_order_bursts();
		int e0;
		e0 = n_errors;
		read_burst(32'h20c, 4, BTE_WRAP4, CTI_INC);
		read_burst(32'h214, 8, BTE_WRAP8, CTI_INC);
		read_burst(32'h238, 16, BTE_WRAP16, CTI_INC); // spans two lines.
		report_test("wrap bursts", e0);
	endtask

	task automatic byte_write_coherence();
		int e0;
		e0 = n_errors;
		read_burst(32'h300, 1, BTE_LINEAR, CTI_CLASSIC);
		write_word(32'h304, $random(seed), 4'b0011);
		write_word(32'h310, $random(seed), 4'b1000);
		write_word(32'h400, $random(seed), 4'b0101);
		write_word(32'h52c, $random(seed), 4'b1111);
		read_burst(32'h304, 1, BTE_LINEAR, CTI_CLASSIC);
		read_burst(32'h310, 1, BTE_LINEAR, CTI_CLASSIC);
		read_burst(32'h400, 1, BTE_LINEAR, CTI_CLASSIC); // refill after the drain.
		read_burst(32'h520, 4, BTE_WRAP4, CTI_INC);
		report_test("write coherence", e0);
	endtask

	task automatic queue_backpressure();
		int e0;
		logic [31:0] adr;
		logic [3:0] sel;
		e0 = n_errors;
		wait_mem_idle(0);
		seen_q.delete();
		exp_q.delete();
		ack_delay = 8'd6;
		for (int i = 0; i < 12; i++) begin
			adr = 32'h600 | ($random(seed) & 32'hfc);
			sel = $random(seed);
			if (sel == 4'h0)
				sel = 4'h1;
			write_word(adr, $random(seed), sel);
		end
		wait_mem_idle(12);
		for (int i = 0; i < exp_q.size() && i < seen_q.size(); i++)
			check_cmd(seen_q[i], exp_q[i], $sformatf("memory write %0d", i));
		check_word(seen_q.size(), exp_q.size(), "memory write count");
		for (int i = 0; i < 1024; i++)
			check_word(u_mem.mem[i], shadow[i], $sformatf("memory word %0d", i));
		report_test("back-pressure", e0);
	endtask

	initial begin
		seed = 32'h94e6fce2;
		n_checks = 0;
		n_errors = 0;
		req_seen = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_req = '0;
		ack_delay = 8'd0;
		sdram_rst = 1'b1;
		for (int i = 0; i < 1024; i++)
			shadow[i] = i ^ 32'h5a5a0000;
		repeat (8) @(negedge wb_clk);
		sdram_rst = 1'b0;
		@(negedge wb_clk);
		reset_first_read();
		linear_hit_burst();
		wrap_order_bursts();
		byte_write_coherence();
		queue_backpressure();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: wb_slave_port.sv
// Wishbone front end of the SDRAM port: decodes cycles, serves line hits and posts writes.
`default_nettype none
`timescale 1ns/100ps

module wb_slave_port import sdram_port_pkg::*; #(
	parameter int line_log2 = DEF_LINE_LOG2
) (
	input  wire logic                 wb_clk,
	input  wire logic                 sdram_rst,
	input  wire logic                 wb_cyc_i,
	input  wire logic                 wb_stb_i,
	input  wire wb_req_t              wb_req_i,
	output logic [31:0]               wb_dat_o,
	output logic                      wb_ack_o,
	input  wire logic                 wq_full_i,
	output logic                      wq_push_o,
	output wr_entry_t                 wq_data_o,
	output logic                      refill_req_o,
	output logic [31:0]               refill_adr_o,
	input  wire logic                 refill_done_i,
	input  wire logic [(1<<line_log2)-1:0] clean_i,
	output logic [line_log2-1:0]      buf_adr_o,
	output logic [3:0]                buf_we_o,
	output logic [31:0]               buf_wdata_o,
	input  wire logic [31:0]          buf_rdata_i
);

	localparam int TAG_LSB = line_log2 + 2; // lowest address bit of the line tag.

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_REFILL
	} state_e;

	state_e             state;
	logic               rd_ack;
	logic               first_req;     // no line has been requested since reset.
	logic [31:TAG_LSB]  buf_tag;
	wr_entry_t          wr_entry;
	logic               wr_buf_hit;
	logic [31:0]        next_adr;
	logic               req_valid;
	logic               cur_hit;
	logic               next_hit;
	cti_e               cti;
	bte_e               bte;

	assign cti       = cti_e'(wb_req_i.cti);
	assign bte       = bte_e'(wb_req_i.bte);
	assign req_valid = wb_cyc_i && wb_stb_i;

	// ########################################################################
	// burst address and hit detection
	// ########################################################################

	// the low bits step by one word and wrap inside the block, upper bits hold.
	always_comb begin
		case (bte)
			BTE_LINEAR: next_adr = wb_req_i.adr + 32'd4;
			BTE_WRAP4:  next_adr = {wb_req_i.adr[31:4], wb_req_i.adr[3:0] + 4'd4};
			BTE_WRAP8:  next_adr = {wb_req_i.adr[31:5], wb_req_i.adr[4:0] + 5'd4};
			default:    next_adr = {wb_req_i.adr[31:6], wb_req_i.adr[5:0] + 6'd4};
		endcase
	end

	// a word hits only once the engine has stored it in the current line.
	assign cur_hit  = !first_req && (wb_req_i.adr[31:TAG_LSB] == buf_tag) &&
			  clean_i[wb_req_i.adr[TAG_LSB-1:2]];
	assign next_hit = !first_req && (next_adr[31:TAG_LSB] == buf_tag) &&
			  clean_i[next_adr[TAG_LSB-1:2]];

	// ########################################################################
	// control
	// ########################################################################

	always_ff @(posedge wb_clk) begin
		if (sdram_rst) begin
			state        <= ST_IDLE;
			rd_ack       <= 1'b0;
			refill_req_o <= 1'b0;
			first_req    <= 1'b1;
		end else begin
			rd_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_valid && !wb_req_i.we) begin
						if (cur_hit) begin
							rd_ack <= 1'b1;
							state  <= ST_READ;
						end else if (!refill_done_i) begin
							// wait for the engine to drop done from the last refill.
							refill_req_o <= 1'b1;
							first_req    <= 1'b0;
							state        <= ST_REFILL;
						end
					end else if (req_valid && wb_req_i.we) begin
						state <= ST_WRITE;
					end
				end
				ST_READ: begin
					// keep streaming while the burst continues inside the buffer.
					if (req_valid && !wb_req_i.we && cti == CTI_INC && next_hit)
						rd_ack <= 1'b1;
					else
						state <= ST_IDLE;
				end
				ST_WRITE: begin
					if (!wq_full_i)
						state <= ST_IDLE; // the entry is pushed in this cycle.
				end
				ST_REFILL: begin
					if (refill_done_i) begin
						refill_req_o <= 1'b0;
						state        <= ST_IDLE; // the request is retried as a hit.
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// captured request fields.
	always_ff @(posedge wb_clk) begin
		if (state == ST_IDLE && req_valid) begin
			if (wb_req_i.we) begin
				wr_entry.adr <= wb_req_i.adr[31:2];
				wr_entry.dat <= wb_req_i.dat;
				wr_entry.sel <= wb_req_i.sel;
				wr_buf_hit   <= cur_hit;
			end else if (!cur_hit && !refill_done_i) begin
				buf_tag      <= wb_req_i.adr[31:TAG_LSB];
				refill_adr_o <= {wb_req_i.adr[31:2], 2'b00};
			end
		end
	end

	// ########################################################################
	// outputs
	// ########################################################################

	assign wq_push_o = (state == ST_WRITE) && !wq_full_i;
	assign wq_data_o = wr_entry;
	assign wb_ack_o  = rd_ack || wq_push_o;
	assign wb_dat_o  = buf_rdata_i;

	// a write to the buffered line updates the same bytes in the buffer.
	assign buf_we_o    = (state == ST_WRITE && wr_buf_hit) ? wr_entry.sel : 4'b0000;
	assign buf_wdata_o = wr_entry.dat;

	// during a burst the next word is read while the current one is acked.
	always_comb begin
		if (state == ST_WRITE)
			buf_adr_o = wr_entry.adr[line_log2-1:0];
		else if (state == ST_READ && cti == CTI_INC)
			buf_adr_o = next_adr[TAG_LSB-1:2];
		else
			buf_adr_o = wb_req_i.adr[TAG_LSB-1:2];
	end

endmodule

`default_nettype wire
